//--- logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire limn_pkg::word_t   inst,
    input  wire limn_pkg::word_t   inst_pc,
    input  wire logic              inst_valid,
    input  wire logic              wb_en,
    input  wire limn_pkg::reg_idx_t wb_reg,
    input  wire limn_pkg::word_t   wb_value,
    output logic                   halt,
    decoded_if.source              out
);
    import limn_pkg::*;

    word_t regs [num_regs];

    // Field split
    wire opcode_t    op_lo   = inst[5:0];
    wire [5:0]       op_hi   = inst[31:26];
    wire reg_idx_t   r1      = inst[10:6];
    wire reg_idx_t   r2      = inst[15:11];
    wire reg_idx_t   r3      = inst[20:16];
    wire [4:0]       imm5    = inst[15:11];
    wire [4:0]       imm5_lo = inst[25:21];  // Shift amount, register group
    wire [15:0]      imm16   = inst[31:16];
    wire [20:0]      imm21   = inst[31:11];
    wire [28:0]      imm29   = inst[31:3];

    wire word_t rv1 = (r1 == '0) ? '0 : regs[r1];  // r0 reads as zero
    wire word_t rv2 = (r2 == '0) ? '0 : regs[r2];
    wire word_t rv3 = (r3 == '0) ? '0 : regs[r3];

    inst_kind_t  kind;
    alu_op_t     alu_op;
    shift_mode_t mode;
    logic [4:0]  amount;
    word_t       a, b, store_data, offset;
    reg_idx_t    rd;
    br_cond_t    cond;

    always_ff @(posedge clk) begin
        if (wb_en && wb_reg != '0) regs[wb_reg] <= wb_value;
    end

    always_comb begin
        kind       = kind_nop;
        alu_op     = alu_or;
        mode       = shift_left;
        amount     = '0;
        a          = rv2;
        b          = '0;
        store_data = rv2;
        rd         = r1;
        offset     = {{14{imm16[15]}}, imm16, 2'b00};
        cond       = br_j;
        casez (op_lo)
            op_jalr: begin
                kind = kind_branch;
                cond = br_jalr;
            end
            6'b???11?: begin  // JAL, or J when bit 0 is clear
                kind   = kind_branch;
                cond   = inst[0] ? br_jal : br_j;
                rd     = link_reg;
                offset = {1'b0, imm29, 2'b00};
            end
            op_beq, op_bne, op_blt: begin
                kind   = kind_branch;
                a      = rv1;
                offset = {{9{imm21[20]}}, imm21, 2'b00};
                cond   = (op_lo == op_beq) ? br_beq : (op_lo == op_bne) ? br_bne : br_blt;
            end
            6'b???100: begin
                kind = kind_alu;
                if (op_lo[5:3] == 3'b000) begin  // LUI
                    b = {imm16, 16'h0};
                end else begin
                    alu_op = alu_op_t'(op_lo[5:3]);
                    b      = {16'h0, imm16};
                end
            end
            6'b1??011: begin
                kind   = kind_load;
                offset = {14'h0, imm16, 2'b00};
            end
            6'b???010: begin
                kind       = kind_store;
                a          = rv1;
                offset     = {14'h0, imm16, 2'b00};
                store_data = op_lo[5] ? rv2 : {27'h0, imm5};  // Register or small immediate
            end
            op_reg_alu: begin
                if (!op_hi[5]) begin  // Upper half holds the dropped indexed moves
                    kind   = kind_alu;
                    alu_op = alu_op_t'(op_hi[4:2]);
                    b      = rv3;
                    mode   = shift_mode_t'(inst[27:26]);
                    amount = imm5_lo;
                end
            end
            op_priv: if (op_hi[5:2] == fn_hlt) kind = kind_halt;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            halt      <= 1'b0;
        end else if (inst_valid) begin
            out.valid <= 1'b1;
            halt      <= (kind == kind_halt);
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            out.kind         <= kind;
            out.alu_op       <= alu_op;
            out.shift_mode   <= mode;
            out.shift_amount <= amount;
            out.a            <= a;
            out.b            <= b;
            out.store_data   <= store_data;
            out.rd           <= rd;
            out.pc           <= inst_pc;
            out.offset       <= offset;
            out.cond         <= cond;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input wire logic  clk,
    input wire logic  rst,
    decoded_if.sink   in,
    result_if.source  out
);
    import limn_pkg::*;

    word_t       shifted;
    word_t       alu_res;
    word_t       link;
    word_t       target;
    word_t       value;
    word_t       next_pc;
    logic [63:0] rot;
    logic        taken;
    logic        write_reg;

    assign in.ready = !out.valid || out.ready;
    assign link     = in.pc + word_bytes;
    assign rot      = {in.b, in.b} >> in.shift_amount;

    //////////////////////////////
    // Shifter and ALU

    always_comb begin
        case (in.shift_mode)
            shift_left:  shifted = in.b << in.shift_amount;
            shift_right: shifted = in.b >> in.shift_amount;
            shift_arith: shifted = $signed(in.b) >>> in.shift_amount;
            default:     shifted = rot[31:0];  // Rotate right
        endcase

        case (in.alu_op)
            alu_add:  alu_res = in.a + shifted;
            alu_sub:  alu_res = in.a - shifted;
            alu_and:  alu_res = in.a & shifted;
            alu_xor:  alu_res = in.a ^ shifted;
            alu_or:   alu_res = in.a | shifted;
            alu_slt:  alu_res = {31'h0, in.a < shifted};
            alu_slts: alu_res = {31'h0, $signed(in.a) < $signed(shifted)};
            default:  alu_res = ~(in.a | shifted);  // NOR
        endcase
    end

    //////////////////////////////
    // Branches and addresses

    always_comb begin
        taken  = 1'b1;
        target = in.pc + in.offset;
        case (in.cond)
            br_beq:  taken = (in.a == '0);
            br_bne:  taken = (in.a != '0);
            br_blt:  taken = in.a[31];
            br_jalr: target = in.a + in.offset;
            default: target = {in.pc[31], in.offset[30:0]};  // J/JAL keep the top PC bit
        endcase

        next_pc   = link;
        value     = alu_res;
        write_reg = 1'b0;
        case (in.kind)
            kind_alu: write_reg = 1'b1;
            kind_load, kind_store: begin
                value     = in.a + in.offset;
                write_reg = (in.kind == kind_load);
            end
            kind_branch: begin
                value     = link;
                write_reg = (in.cond == br_jal) || (in.cond == br_jalr);
                if (taken) next_pc = target;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (in.valid && in.ready) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out.kind       <= in.kind;
            out.rd         <= in.rd;
            out.value      <= value;
            out.store_data <= in.store_data;
            out.write_reg  <= write_reg;
            out.next_pc    <= next_pc;
        end
    end

    a_valid_known: assert property (@(posedge clk) !rst |-> !$isunknown(out.valid));

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter limn_pkg::word_t reset_pc = 32'hFFFE0000
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            retire,
    input  wire limn_pkg::word_t retire_pc,
    input  wire logic            halt,
    output logic                 halted,
    output limn_pkg::word_t      inst,
    output limn_pkg::word_t      inst_pc,
    output logic                 inst_valid,
    bus_if.requester             bus
);
    import limn_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_wait, st_halted} fetch_state_t;

    fetch_state_t state;
    word_t        pc;

    assign bus.req  = (state == st_fetch);
    assign bus.addr = pc;
    assign halted   = (state == st_halted);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_fetch;
            pc         <= reset_pc;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;  // One-cycle handoff
            case (state)
                st_fetch: begin
                    if (bus.done) begin
                        inst       <= bus.rdata;
                        inst_pc    <= pc;
                        inst_valid <= 1'b1;
                        state      <= st_wait;
                    end
                end
                st_wait: begin
                    if (retire) begin
                        pc    <= retire_pc;
                        state <= halt ? st_halted : st_fetch;
                    end
                end
                default: ;  // Stopped for good
            endcase
        end
    end

    // Only one instruction in flight between a fetch and its retirement
    a_no_req_in_flight: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.req) |-> $past(retire));

endmodule

`default_nettype wire

//--- logic/limn_core.sv
`timescale 1ns/100ps
`default_nettype none

module limn_core #(
    parameter limn_pkg::word_t reset_pc = 32'hFFFE0000
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire limn_pkg::word_t data_in,
    input  wire logic            rdy,
    output limn_pkg::word_t      addr,
    output limn_pkg::word_t      data_out,
    output logic                 we,
    output logic                 cs,
    output logic                 halted
);
    import limn_pkg::*;

    bus_if     fetch_bus ();
    decoded_if dec ();
    result_if  res ();

    word_t    inst, inst_pc;
    logic     inst_valid;
    logic     halt;
    logic     retire;
    word_t    retire_pc;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_value;

    fetch_stage #(.reset_pc(reset_pc)) fetch_i (
        .clk(clk), .rst(rst), .retire(retire), .retire_pc(retire_pc), .halt(halt),
        .halted(halted), .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid),
        .bus(fetch_bus)
    );

    decode_stage decode_i (
        .clk(clk), .rst(rst), .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_value(wb_value), .halt(halt), .out(dec)
    );

    execute_stage execute_i (.clk(clk), .rst(rst), .in(dec), .out(res));

    // Sole owner of the external bus
    mem_stage mem_i (
        .clk(clk), .rst(rst), .data_in(data_in), .rdy(rdy), .addr(addr),
        .data_out(data_out), .we(we), .cs(cs), .retire(retire), .retire_pc(retire_pc),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_value(wb_value),
        .fetch_bus(fetch_bus), .in(res)
    );

endmodule

`default_nettype wire

//--- logic/limn_pkg.sv
`default_nettype none

package limn_pkg;

    //////////////////////////////
    // Widths and constants

    typedef logic [31:0] word_t;    // Data word, address or instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;  // inst[5:0]

    localparam int       num_regs   = 32;
    localparam reg_idx_t link_reg   = 5'd31;
    localparam word_t    word_bytes = 32'd4;   // PC step

    //////////////////////////////
    // Opcode fields

    localparam opcode_t op_jalr    = 6'b111000;
    localparam opcode_t op_beq     = 6'b111101;
    localparam opcode_t op_bne     = 6'b110101;
    localparam opcode_t op_blt     = 6'b101101;
    localparam opcode_t op_reg_alu = 6'b111001;
    localparam opcode_t op_priv    = 6'b101001;

    // Function code in inst[31:28] of the privileged group
    localparam logic [3:0] fn_hlt = 4'b1100;

    //////////////////////////////
    // Enums

    typedef enum logic [2:0] {
        alu_none = 3'b000,  // Register group uses this code for NOR
        alu_or   = 3'b001,
        alu_xor  = 3'b010,
        alu_and  = 3'b011,
        alu_slts = 3'b100,
        alu_slt  = 3'b101,
        alu_sub  = 3'b110,
        alu_add  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        shift_left  = 2'b00,
        shift_right = 2'b01,
        shift_arith = 2'b10,
        shift_ror   = 2'b11
    } shift_mode_t;

    typedef enum logic [2:0] {
        kind_alu, kind_load, kind_store, kind_branch, kind_halt, kind_nop
    } inst_kind_t;

    typedef enum logic [2:0] {
        br_j, br_jal, br_jalr, br_beq, br_bne, br_blt
    } br_cond_t;

endpackage

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire limn_pkg::word_t   data_in,
    input  wire logic              rdy,
    output limn_pkg::word_t        addr,
    output limn_pkg::word_t        data_out,
    output logic                   we,
    output logic                   cs,
    output logic                   retire,
    output limn_pkg::word_t        retire_pc,
    output logic                   wb_en,
    output limn_pkg::reg_idx_t     wb_reg,
    output limn_pkg::word_t        wb_value,
    bus_if.owner                   fetch_bus,
    result_if.sink                 in
);
    import limn_pkg::*;

    typedef enum logic [1:0] {ms_idle, ms_fetch, ms_data} mem_state_t;

    mem_state_t state;
    logic       is_load;

    wire fetch_pending = fetch_bus.req && !fetch_bus.done;
    wire accept        = in.valid && in.ready;
    wire is_mem        = (in.kind == kind_load) || (in.kind == kind_store);

    assign in.ready = (state == ms_idle) && !fetch_bus.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ms_idle;
            cs             <= 1'b0;
            we             <= 1'b0;
            retire         <= 1'b0;
            wb_en          <= 1'b0;
            fetch_bus.done <= 1'b0;
        end else begin
            retire         <= 1'b0;
            wb_en          <= 1'b0;
            fetch_bus.done <= 1'b0;
            case (state)
                ms_idle: begin
                    if (fetch_pending) begin
                        state <= ms_fetch;
                        cs    <= 1'b1;
                    end else if (accept && is_mem) begin
                        state <= ms_data;
                        cs    <= 1'b1;
                        we    <= (in.kind == kind_store);
                    end else if (accept) begin  // Nothing to move, retire now
                        retire <= 1'b1;
                        wb_en  <= in.write_reg;
                    end
                end
                ms_fetch: begin
                    if (rdy) begin
                        state          <= ms_idle;
                        cs             <= 1'b0;
                        fetch_bus.done <= 1'b1;
                    end
                end
                default: begin
                    if (rdy) begin
                        state  <= ms_idle;
                        cs     <= 1'b0;
                        we     <= 1'b0;
                        retire <= 1'b1;
                        wb_en  <= is_load;
                    end
                end
            endcase
        end
    end

    // Bus address, data and writeback payload
    always_ff @(posedge clk) begin
        if (state == ms_idle && fetch_pending) addr <= fetch_bus.addr;
        if (accept) begin
            addr      <= in.value;
            data_out  <= in.store_data;
            is_load   <= (in.kind == kind_load);
            wb_reg    <= in.rd;
            wb_value  <= in.value;
            retire_pc <= in.next_pc;
        end
        if (state == ms_fetch && rdy) fetch_bus.rdata <= data_in;
        if (state == ms_data && rdy) wb_value <= data_in;
    end

    a_we_in_cs: assert property (@(posedge clk) disable iff (rst) we |-> cs);

endmodule

`default_nettype wire

//--- logic/stage_if.sv
`timescale 1ns/100ps
`default_nettype none

// Instruction fetch path to the bus owner
interface bus_if;
    import limn_pkg::*;
    logic  req;    // Held until done
    word_t addr;
    word_t rdata;  // Valid while done is high
    logic  done;

    modport requester (output req, addr, input rdata, done);
    modport owner (input req, addr, output rdata, done);
endinterface

interface decoded_if;
    import limn_pkg::*;
    logic        valid;
    logic        ready;
    inst_kind_t  kind;
    alu_op_t     alu_op;
    shift_mode_t shift_mode;
    logic [4:0]  shift_amount;
    word_t       a;
    word_t       b;
    word_t       store_data;
    reg_idx_t    rd;
    word_t       pc;
    word_t       offset;  // Branch or load/store displacement
    br_cond_t    cond;

    modport source (output valid, kind, alu_op, shift_mode, shift_amount, a, b,
                    store_data, rd, pc, offset, cond, input ready);
    modport sink (input valid, kind, alu_op, shift_mode, shift_amount, a, b,
                  store_data, rd, pc, offset, cond, output ready);
endinterface

interface result_if;
    import limn_pkg::*;
    logic       valid;
    logic       ready;
    inst_kind_t kind;
    reg_idx_t   rd;
    word_t      value;       // ALU result or effective address
    word_t      store_data;
    logic       write_reg;
    word_t      next_pc;

    modport source (output valid, kind, rd, value, store_data, write_reg, next_pc,
                    input ready);
    modport sink (input valid, kind, rd, value, store_data, write_reg, next_pc,
                  output ready);
endinterface

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module core_tb \
    -Mdir obj_dir -o core_sim -f sim.f \
    && ./obj_dir/core_sim | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "^Result: PASSED$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

//--- sim.f
logic/limn_pkg.sv
logic/stage_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/limn_core.sv
test/core_checker.sv
test/core_tb.sv

//--- test/core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module core_checker #(
    parameter logic [31:0] reset_pc = 32'hFFFE0000
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] data_out,
    input  wire logic        we,
    input  wire logic        cs,
    input  wire logic        rdy,
    input  wire logic        halted,
    output int               mismatches,
    output int               protocol_errors,
    output int               pending
);
    import limn_pkg::*;

    logic [63:0] exp_q [$];  // {address, data} in program order
    int          mismatch_count = 0;
    int          protocol_count = 0;
    logic        first_seen     = 1'b0;

    assign mismatches      = mismatch_count;
    assign protocol_errors = protocol_count;
    assign pending         = exp_q.size();

    //////////////////////////////
    // Reference model

    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] x,
                                            input logic [31:0] y, input logic [1:0] mode,
                                            input logic [4:0] amt);
        logic [31:0] s;
        case (mode)
            shift_left:  s = y << amt;
            shift_right: s = y >> amt;
            shift_arith: s = $unsigned($signed(y) >>> amt);
            default:     s = (amt == 5'd0) ? y : (y >> amt) | (y << (6'd32 - {1'b0, amt}));
        endcase
        case (op)
            alu_add:  return x + s;
            alu_sub:  return x - s;
            alu_and:  return x & s;
            alu_xor:  return x ^ s;
            alu_or:   return x | s;
            alu_slt:  return (x < s) ? 32'd1 : 32'd0;
            alu_slts: return ($signed(x) < $signed(s)) ? 32'd1 : 32'd0;
            default:  return ~(x | s);  // NOR
        endcase
    endfunction

    task automatic expect_word(input logic [31:0] a, input logic [31:0] d);
        exp_q.push_back({a, d});
    endtask

    task automatic expect_alu(input logic [31:0] a, input logic [2:0] op,
                              input logic [31:0] x, input logic [31:0] y,
                              input logic [1:0] mode, input logic [4:0] amt);
        exp_q.push_back({a, alu_ref(op, x, y, mode, amt)});
    endtask

    //////////////////////////////
    // Bus monitors

    always @(negedge clk) begin
        if (rst && (cs !== 1'b0 || we !== 1'b0)) begin
            protocol_count++;
            $display("[FAIL] %0t: cs=%b we=%b while in reset", $time, cs, we);
        end
    end

    always @(posedge clk) begin : watch_bus
        logic [63:0] head;
        if (!rst && cs) begin
            if (!first_seen && (we || addr !== reset_pc)) begin
                mismatch_count++;
                $display("[FAIL] %0t: first access at %h we=%b, expected a read at %h",
                         $time, addr, we, reset_pc);
            end
            first_seen = 1'b1;
            if (halted) begin
                protocol_count++;
                $display("Bus access to %h after the core halted, at time %0t", addr, $time);
            end
            if (we && rdy) begin
                if (exp_q.size() == 0) begin
                    protocol_count++;
                    $display("Store to %h with no expected value left, at time %0t",
                             addr, $time);
                end else begin
                    head = exp_q.pop_front();
                    if (addr !== head[63:32] || data_out !== head[31:0]) begin
                        mismatch_count++;
                        $display("[FAIL] %0t: store %h <= %h, expected %h <= %h", $time,
                                 addr, data_out, head[63:32], head[31:0]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    import limn_pkg::*;

    localparam word_t       prog_base    = 32'hFFFE0000;
    localparam int          mem_words    = 1024;
    localparam logic [31:0] lcg_seed     = 32'hdd6c4d8f;
    localparam int          halt_timeout = 50000;
    localparam int          quiet_cycles = 20;        // Bus watch after halt
    localparam logic [15:0] data_slot0   = 16'h0200;  // Data area at base + 0x800

    logic  clk     = 1'b0;
    logic  rst     = 1'b1;
    logic  rdy     = 1'b0;
    word_t data_in = '0;
    word_t addr;
    word_t data_out;
    logic  we;
    logic  cs;
    logic  halted;

    word_t       mem [mem_words];
    logic [31:0] gen_state;
    logic [31:0] bus_state = lcg_seed;
    logic [9:0]  wp;    // Next program word
    logic [15:0] slot;  // Next free data word
    int          timeouts;
    int          total;
    int          mismatches;
    int          protocol_errors;
    int          pending;

    always #50 clk = ~clk;

    limn_core #(.reset_pc(prog_base)) limn_core_i (
        .clk(clk), .rst(rst), .data_in(data_in), .rdy(rdy), .addr(addr),
        .data_out(data_out), .we(we), .cs(cs), .halted(halted)
    );

    core_checker #(.reset_pc(prog_base)) checker_i (
        .clk(clk), .rst(rst), .addr(addr), .data_out(data_out), .we(we), .cs(cs),
        .rdy(rdy), .halted(halted), .mismatches(mismatches),
        .protocol_errors(protocol_errors), .pending(pending)
    );

    //////////////////////////////
    // Memory model

    always @(negedge clk) begin
        if (!rst && cs) begin
            bus_state = lcg_next(bus_state);
            rdy = (bus_state[31:30] != 2'b00);  // Roughly one stall in four
            if (rdy && we) mem[addr[11:2]] = data_out;
            data_in = mem[addr[11:2]];
        end else begin
            rdy = 1'b0;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t pc_of(input logic [9:0] w);
        return prog_base + {20'h0, w, 2'b00};
    endfunction

    //////////////////////////////
    // Program generator

    task automatic rand_word(output word_t w);
        gen_state = lcg_next(gen_state);
        w[31:16] = gen_state[31:16];
        gen_state = lcg_next(gen_state);
        w[15:0] = gen_state[31:16];
    endtask

    task automatic emit(input word_t w);
        mem[wp] = w;
        wp = wp + 10'd1;
    endtask

    task automatic load_const(input reg_idx_t r, input word_t v);
        emit({v[31:16], 5'd0, r, 6'b000100});  // LUI from r0
        emit({v[15:0], r, r, 6'b001100});      // ORI
    endtask

    // Word store through base r3; reg form, or imm5 form when is_reg is low
    task automatic store_fresh(input logic is_reg, input logic [4:0] field, output word_t a);
        logic [15:0] off;
        off = data_slot0 + slot;
        emit({off, field, 5'd3, is_reg, 5'b11010});
        a = prog_base + {14'h0, off, 2'b00};
        slot = slot + 16'd1;
    endtask

    task automatic imm_test(input logic [2:0] op, input logic near_zero);
        word_t x;
        word_t r;
        word_t a;
        rand_word(x);
        rand_word(r);
        if (near_zero) x = {{16{x[15]}}, x[15:0]};  // Small signed value
        load_const(5'd1, x);
        emit({r[15:0], 5'd1, 5'd4, op, 3'b100});
        store_fresh(1'b1, 5'd4, a);
        if (op == 3'b000)  // LUI
            checker_i.expect_alu(a, alu_or, x, {r[15:0], 16'h0}, shift_left, 5'd0);
        else
            checker_i.expect_alu(a, op, x, {16'h0, r[15:0]}, shift_left, 5'd0);
    endtask

    task automatic reg_test(input logic [2:0] op, input logic [1:0] mode);
        word_t x;
        word_t y;
        word_t r;
        word_t a;
        rand_word(x);
        rand_word(y);
        rand_word(r);
        load_const(5'd1, x);
        load_const(5'd2, y);
        emit({1'b0, op, mode, r[20:16], 5'd2, 5'd1, 5'd4, 6'b111001});
        store_fresh(1'b1, 5'd4, a);
        checker_i.expect_alu(a, op, x, y, mode, r[20:16]);
    endtask

    task automatic branch_test(input opcode_t op, input word_t v);
        logic  taken;
        word_t a;
        taken = (op == op_beq) ? (v == '0) : (op == op_bne) ? (v != '0) : v[31];
        load_const(5'd1, v);
        emit({21'd2, 5'd1, op});      // Skips the next word when taken
        store_fresh(1'b0, 5'h15, a);  // Marker
        if (!taken) checker_i.expect_word(a, 32'h15);
        store_fresh(1'b0, 5'h0A, a);
        checker_i.expect_word(a, 32'h0A);
    endtask

    task automatic jal_test;
        word_t p;
        word_t t;
        word_t a;
        p = pc_of(wp);
        t = p + 32'd8;
        emit({t[30:2], 3'b111});
        store_fresh(1'b0, 5'h15, a);  // Jumped over
        store_fresh(1'b1, 5'd31, a);
        checker_i.expect_word(a, p + 32'd4);
    endtask

    task automatic load_test;
        word_t x;
        word_t a;
        word_t b;
        word_t d;
        rand_word(x);
        load_const(5'd1, x);
        store_fresh(1'b1, 5'd1, a);
        checker_i.expect_word(a, x);
        d = a - prog_base;
        emit({d[17:2], 5'd3, 5'd5, 6'b111011});  // r5 from the stored word
        store_fresh(1'b1, 5'd5, b);
        checker_i.expect_word(b, x);
    endtask

    task automatic build_program;
        word_t v;
        wp = '0;
        slot = '0;
        emit({prog_base[31:16], 5'd0, 5'd3, 6'b000100});  // r3 holds the base
        for (int k = 0; k < 24; k++) imm_test(k[2:0], k >= 16);
        for (int k = 0; k < 32; k++) reg_test(k[2:0], k[4:3]);
        rand_word(v);
        branch_test(op_beq, 32'h0);
        branch_test(op_beq, v | 32'h1);
        branch_test(op_bne, 32'h0);
        branch_test(op_bne, v | 32'h1);
        branch_test(op_blt, v | 32'h80000000);
        branch_test(op_blt, v & 32'h7FFFFFFF);
        jal_test();
        jal_test();
        for (int k = 0; k < 4; k++) load_test();
        emit(32'hC0000029);  // HLT
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        timeouts = 0;
        gen_state = lcg_seed;
        for (int i = 0; i < mem_words; i++) begin
            mem[i[9:0]] = (prog_base + (i << 2)) ^ 32'h5A5AA5A5;
        end
        build_program();
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < halt_timeout && !halted; n++) @(negedge clk);
        if (!halted) begin
            timeouts++;
            $display("Timeout: core did not halt within %0d cycles", halt_timeout);
        end
        repeat (quiet_cycles) @(negedge clk);

        total = mismatches + protocol_errors + timeouts + pending;
        $display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d stores missing",
                 mismatches, protocol_errors, timeouts, pending);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
